// ==== all.f ====
+incdir+src
src/ncpu_pkg.sv
src/epu_irqc.sv
src/epu_msr_file.sv
src/epu_irq_entry.sv
src/epu_top.sv
dv/tb_epu.sv

// ==== dv/tb_epu.sv ====
//****************************************
// Directed testbench for the EPU interrupt slice
// Plays the core on the MSR, retire and IRQ ports
//****************************************

`timescale 1ns/1ps

`include "ncpu_config.svh"

module tb_epu;
   import ncpu_pkg::*;

   // Longest wait for a redirect, in cycles
   localparam int FLUSH_TIMEOUT = 8;

   logic                     clk;
   logic                     arst_n;
   logic [`NCPU_NUM_IRQ-1:0] irqs;
   msr_addr_e                msr_addr;
   logic                     msr_we;
   word_t                    msr_wdat;
   logic                     retire_valid;
   addr_t                    retire_pc;
   logic                     eret;
   word_t                    msr_rdat;
   logic                     flush;
   addr_t                    flush_pc;

   int    errors;
   int    checks;
   word_t rng;

   // Carried from interrupt entry into the return test
   addr_t evect_exp;
   addr_t epc_exp;
   int    irq_line;

   epu_top epu_top_i (
      .clk, .arst_n, .irqs, .msr_addr, .msr_we, .msr_wdat,
      .retire_valid, .retire_pc, .eret, .msr_rdat, .flush, .flush_pc
   );

   always #5 clk = ~clk;

   function automatic word_t xorshift32(input word_t x);
      word_t y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic next_rand(output word_t r);
      rng = xorshift32(rng);
      r = rng;
   endtask

   task automatic idle(input int n);
      repeat (n) @(negedge clk);
   endtask

   // Write strobe held for one rising edge
   task automatic msr_write(input msr_addr_e addr, input word_t data);
      @(negedge clk);
      msr_addr = addr;
      msr_wdat = data;
      msr_we   = 1'b1;
      @(negedge clk);
      msr_we = 1'b0;
   endtask

   // Read data is combinational, sampled just after the drive
   task automatic msr_read_check(input msr_addr_e addr, input word_t exp, input string what);
      @(negedge clk);
      msr_addr = addr;
      msr_we   = 1'b0;
      #1;
      checks++;
      if (msr_rdat !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s read %h, expected %h", $time, what, msr_rdat, exp);
      end
   endtask

   // Ends on the falling edge right after the sampling edge
   task automatic retire(input addr_t pc, input logic is_eret);
      @(negedge clk);
      retire_valid = 1'b1;
      retire_pc    = pc;
      eret         = is_eret;
      @(negedge clk);
      retire_valid = 1'b0;
      eret         = 1'b0;
   endtask

   task automatic check_no_flush(input string what);
      checks++;
      if (flush !== 1'b0) begin
         errors++;
         $display("CHECK FAILED at %0t: unexpected flush, %s", $time, what);
      end
   endtask

   // Called right after retire, so a flush on time means no wait
   task automatic wait_flush(output addr_t target);
      int waited;
      waited = 0;
      while (flush !== 1'b1 && waited < FLUSH_TIMEOUT) begin
         @(negedge clk);
         waited++;
      end
      target = flush_pc;
      if (flush !== 1'b1) begin
         errors++;
         $display("Timed out: no flush within %0d cycles after a retirement", waited);
      end else begin
         checks++;
         if (waited != 0) begin
            errors++;
            $display("CHECK FAILED at %0t: flush came %0d cycles late", $time, waited);
         end
         // One-cycle pulse, also keeps the next retire out of the flush shadow
         @(negedge clk);
         check_no_flush("flush held a second cycle");
      end
   endtask

   task automatic test_reset_values();
      addr_t rst_vec;
      rst_vec = `NCPU_EVECT_RST;
      // No rising edge since release, flush still holds its reset value
      check_no_flush("at reset release");
      msr_read_check(MSR_PSR, '0, "PSR at reset");
      msr_read_check(MSR_EPSR, '0, "EPSR at reset");
      msr_read_check(MSR_EPC_LO, '0, "EPC low at reset");
      msr_read_check(MSR_EPC_HI, '0, "EPC high at reset");
      msr_read_check(MSR_EVECT_LO, rst_vec[`NCPU_DW-1:0], "EVECT low at reset");
      msr_read_check(MSR_EVECT_HI, rst_vec[`NCPU_AW-1:`NCPU_DW], "EVECT high at reset");
      msr_read_check(MSR_IMR, '1, "IMR at reset");
      msr_read_check(MSR_IRR, '0, "IRR at reset");
      repeat (4) begin
         @(negedge clk);
         check_no_flush("after reset");
      end
   endtask

   task automatic test_irr_imr();
      word_t                    r;
      logic [`NCPU_NUM_IRQ-1:0] pat;
      for (int i = 0; i < 4; i++) begin
         next_rand(r);
         pat = r[`NCPU_NUM_IRQ-1:0];
         @(negedge clk);
         irqs = pat;
         // Two synchroniser stages, plus one for odd passes
         idle(2 + i % 2);
         msr_read_check(MSR_IRR, word_t'(pat), "IRR after hold");
         next_rand(r);
         @(negedge clk);
         msr_addr = MSR_IMR;
         msr_wdat = r;
         msr_we   = 1'b1;
         #1;
         checks++;
         if (msr_rdat !== r) begin
            errors++;
            $display("CHECK FAILED at %0t: IMR bypass read %h, expected %h", $time, msr_rdat, r);
         end
         @(negedge clk);
         msr_we = 1'b0;
         #1;
         checks++;
         if (msr_rdat !== r) begin
            errors++;
            $display("CHECK FAILED at %0t: IMR read %h, expected %h", $time, msr_rdat, r);
         end
      end
      @(negedge clk);
      irqs = '0;
      msr_write(MSR_IMR, '1);
   endtask

   task automatic test_irq_entry();
      word_t r;
      word_t hi;
      addr_t pc;
      addr_t target;
      next_rand(r);
      irq_line = int'(r % `NCPU_NUM_IRQ);
      next_rand(hi);
      next_rand(r);
      evect_exp = {hi, r & 32'hffff_fffc};
      msr_write(MSR_EVECT_LO, evect_exp[`NCPU_DW-1:0]);
      msr_write(MSR_EVECT_HI, evect_exp[`NCPU_AW-1:`NCPU_DW]);
      msr_write(MSR_IMR, ~(word_t'(1) << irq_line));
      msr_write(MSR_PSR, word_t'(1) << PSR_IRE_BIT);
      @(negedge clk);
      irqs           = '0;
      irqs[irq_line] = 1'b1;
      idle(3);
      next_rand(hi);
      next_rand(r);
      pc      = {hi, r & 32'hffff_fffc};
      epc_exp = pc + addr_t'(4);
      retire(pc, 1'b0);
      wait_flush(target);
      checks++;
      if (target !== evect_exp) begin
         errors++;
         $display("CHECK FAILED at %0t: entry flush_pc %h, expected %h", $time, target, evect_exp);
      end
      msr_read_check(MSR_EPC_LO, epc_exp[`NCPU_DW-1:0], "EPC low after entry");
      msr_read_check(MSR_EPC_HI, epc_exp[`NCPU_AW-1:`NCPU_DW], "EPC high after entry");
      msr_read_check(MSR_EPSR, word_t'(1) << PSR_IRE_BIT, "EPSR after entry");
      msr_read_check(MSR_PSR, '0, "PSR after entry");
      // IRE is now clear, the line stays high
      for (int i = 0; i < 3; i++) begin
         retire(evect_exp + addr_t'(4 * i), 1'b0);
         check_no_flush("retire inside the handler");
      end
   endtask

   task automatic test_eret();
      word_t r;
      word_t hi;
      addr_t pc;
      addr_t target;
      retire(evect_exp + addr_t'(12), 1'b1);
      wait_flush(target);
      checks++;
      if (target !== epc_exp) begin
         errors++;
         $display("CHECK FAILED at %0t: return flush_pc %h, expected %h", $time, target, epc_exp);
      end
      msr_read_check(MSR_PSR, word_t'(1) << PSR_IRE_BIT, "PSR after return");
      // Line still pending, so a plain retire enters again
      next_rand(hi);
      next_rand(r);
      pc      = {hi, r & 32'hffff_fffc};
      epc_exp = pc + addr_t'(4);
      retire(pc, 1'b0);
      wait_flush(target);
      checks++;
      if (target !== evect_exp) begin
         errors++;
         $display("CHECK FAILED at %0t: reentry flush_pc %h, expected %h", $time, target, evect_exp);
      end
      msr_read_check(MSR_EPC_LO, epc_exp[`NCPU_DW-1:0], "EPC low after reentry");
      msr_read_check(MSR_EPC_HI, epc_exp[`NCPU_AW-1:`NCPU_DW], "EPC high after reentry");
   endtask

   task automatic test_gating();
      // IRE clear after the reentry
      for (int i = 0; i < 10; i++) begin
         retire(evect_exp + addr_t'(4 * i), 1'b0);
         check_no_flush("pending line with IRE clear");
      end
      msr_write(MSR_IMR, '1);
      msr_write(MSR_PSR, word_t'(1) << PSR_IRE_BIT);
      msr_read_check(MSR_IRR, word_t'(1) << irq_line, "IRR while masked");
      for (int i = 0; i < 10; i++) begin
         retire(evect_exp + addr_t'(4 * i), 1'b0);
         check_no_flush("pending line masked in IMR");
      end
   endtask

   initial begin
      clk          = 1'b0;
      arst_n       = 1'b0;
      irqs         = '0;
      msr_addr     = MSR_PSR;
      msr_we       = 1'b0;
      msr_wdat     = '0;
      retire_valid = 1'b0;
      retire_pc    = '0;
      eret         = 1'b0;
      errors       = 0;
      checks       = 0;
      rng          = 32'h7d6a;
      irq_line     = 0;
      evect_exp    = '0;
      epc_exp      = '0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      test_reset_values();
      test_irr_imr();
      test_irq_entry();
      test_eret();
      test_gating();
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build the EPU testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_epu -f all.f -o tb_epu \
   || { echo "Verilator build failed"; exit 1; }
./obj_dir/tb_epu > sim.log 2>&1 || echo "Simulator exited with an error status"
cat sim.log
grep -q "^TEST RESULT: PASS$" sim.log \
   && { echo "Simulation passed"; exit 0; } \
   || { echo "Simulation failed"; exit 1; }

// ==== src/epu_irq_entry.sv ====
//****************************************
// Interrupt entry and return at retire
// Issues take pulses and a one-cycle flush
//****************************************

`timescale 1ns/1ps

module epu_irq_entry (
   input  logic            clk,
   input  logic            arst_n,
   input  logic            retire_valid,
   input  logic            eret,
   input  logic            irq_async,
   input  ncpu_pkg::addr_t epc,
   input  ncpu_pkg::addr_t evect,
   output logic            exc_take,
   output logic            eret_take,
   output logic            flush,
   output ncpu_pkg::addr_t flush_pc
);

   // Return goes first
   assign eret_take = retire_valid & eret;

   // Interrupt only on a plain retire
   assign exc_take = retire_valid & ~eret & irq_async;

   // Flush is high for the cycle after a take
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         flush <= 1'b0;
      end else begin
         flush <= exc_take | eret_take;
      end
   end

   // Redirect target
   // EPC for a return, vector for an entry
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         flush_pc <= '0;
      end else if (eret_take) begin
         flush_pc <= epc;
      end else if (exc_take) begin
         flush_pc <= evect;
      end
   end

   // Single-cycle redirect
   a_flush_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
      flush |=> !flush);

   // Core is flushing and cannot retire right after
   a_no_retire_after_flush: assert property (@(posedge clk) disable iff (!arst_n)
      flush |=> !retire_valid);

endmodule

// ==== src/epu_irqc.sv ====
//****************************************
// Interrupt controller: IRQ sync, IMR, IRR
// Raises irq_async for the entry logic
//****************************************

`timescale 1ns/1ps

`include "ncpu_config.svh"

module epu_irqc (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic [`NCPU_NUM_IRQ-1:0] irqs,
   input  logic                     psr_ire,
   input  logic                     imr_we,
   input  ncpu_pkg::word_t          imr_nxt,
   output logic                     irq_async,
   output ncpu_pkg::word_t          imr,
   output ncpu_pkg::word_t          irr
);
   import ncpu_pkg::*;

   logic [`NCPU_NUM_IRQ-1:0] irq_sync0;
   logic [`NCPU_NUM_IRQ-1:0] irq_sync1;
   word_t                    imr_q;

   // Lines are level sensitive and asynchronous
   // Two flops, second stage is IRR itself
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         irq_sync0 <= '0;
         irq_sync1 <= '0;
      end else begin
         irq_sync0 <= irqs;
         irq_sync1 <= irq_sync0;
      end
   end

   // Upper bits read as zero
   assign irr = word_t'(irq_sync1);

   // Mask register, all lines masked out of reset
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         imr_q <= '1;
      end else if (imr_we) begin
         imr_q <= imr_nxt;
      end
   end

   // New mask visible in the write cycle
   assign imr = imr_we ? imr_nxt : imr_q;

   // Any unmasked pending line, gated by PSR.IRE
   assign irq_async = psr_ire & (|(irr & ~imr));

   // More lines than IRR bits is a bad build
   if (`NCPU_NUM_IRQ > `NCPU_DW) begin : g_bad_num_irq
      $fatal(1, "NCPU_NUM_IRQ (%0d) exceeds NCPU_DW (%0d)", `NCPU_NUM_IRQ, `NCPU_DW);
   end

endmodule

// ==== src/epu_msr_file.sv ====
//****************************************
// MSR file: PSR, EPSR, EPC, EVECT and access port
// Saves and restores state on interrupt entry/return
//****************************************

`timescale 1ns/1ps

`include "ncpu_config.svh"

module epu_msr_file (
   input  logic                  clk,
   input  logic                  arst_n,
   input  ncpu_pkg::msr_addr_e   msr_addr,
   input  logic                  msr_we,
   input  ncpu_pkg::word_t       msr_wdat,
   input  logic                  exc_take,
   input  logic                  eret_take,
   input  ncpu_pkg::addr_t       retire_pc,
   input  ncpu_pkg::word_t       imr,
   input  ncpu_pkg::word_t       irr,
   output ncpu_pkg::word_t       msr_rdat,
   output logic                  imr_we,
   output ncpu_pkg::word_t       imr_nxt,
   output logic                  psr_ire,
   output ncpu_pkg::addr_t       epc,
   output ncpu_pkg::addr_t       evect
);
   import ncpu_pkg::*;

   // PSR and EPSR are byte wide
   localparam int PSR_W = 8;

   logic [PSR_W-1:0] psr_q;
   logic [PSR_W-1:0] epsr_q;
   logic             sw_we;
   logic             psr_we;
   logic             epsr_we;
   logic             epc_lo_we;
   logic             epc_hi_we;
   logic             evect_lo_we;
   logic             evect_hi_we;

   // Exception update wins over a core write to saved state
   assign sw_we = msr_we & ~exc_take & ~eret_take;

   // Write decode
   assign psr_we      = sw_we  && (msr_addr == MSR_PSR);
   assign epsr_we     = sw_we  && (msr_addr == MSR_EPSR);
   assign epc_lo_we   = sw_we  && (msr_addr == MSR_EPC_LO);
   assign epc_hi_we   = sw_we  && (msr_addr == MSR_EPC_HI);
   assign evect_lo_we = msr_we && (msr_addr == MSR_EVECT_LO);
   assign evect_hi_we = msr_we && (msr_addr == MSR_EVECT_HI);

   // IMR lives in the controller
   assign imr_we  = msr_we && (msr_addr == MSR_IMR);
   assign imr_nxt = msr_wdat;

   // PSR: entry drops IRE, return restores from EPSR
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         psr_q <= '0;
      end else if (exc_take) begin
         psr_q[PSR_IRE_BIT] <= 1'b0;
      end else if (eret_take) begin
         psr_q <= epsr_q;
      end else if (psr_we) begin
         psr_q <= msr_wdat[PSR_W-1:0];
      end
   end

   assign psr_ire = psr_q[PSR_IRE_BIT];

   // EPSR keeps PSR as it was before entry
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         epsr_q <= '0;
      end else if (exc_take) begin
         epsr_q <= psr_q;
      end else if (epsr_we) begin
         epsr_q <= msr_wdat[PSR_W-1:0];
      end
   end

   // EPC points past the retired instruction
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         epc <= '0;
      end else if (exc_take) begin
         epc <= retire_pc + addr_t'(4);
      end else begin
         if (epc_lo_we) epc[`NCPU_DW-1:0] <= msr_wdat;
         if (epc_hi_we) epc[`NCPU_AW-1:`NCPU_DW] <= msr_wdat[`NCPU_AW-`NCPU_DW-1:0];
      end
   end

   // Vector, software only
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         evect <= `NCPU_EVECT_RST;
      end else begin
         if (evect_lo_we) evect[`NCPU_DW-1:0] <= msr_wdat;
         if (evect_hi_we) evect[`NCPU_AW-1:`NCPU_DW] <= msr_wdat[`NCPU_AW-`NCPU_DW-1:0];
      end
   end

   // Read mux, combinational on current state
   always_comb begin
      case (msr_addr)
         MSR_PSR:      msr_rdat = word_t'(psr_q);
         MSR_EPSR:     msr_rdat = word_t'(epsr_q);
         MSR_EPC_LO:   msr_rdat = epc[`NCPU_DW-1:0];
         MSR_EPC_HI:   msr_rdat = word_t'(epc[`NCPU_AW-1:`NCPU_DW]);
         MSR_EVECT_LO: msr_rdat = evect[`NCPU_DW-1:0];
         MSR_EVECT_HI: msr_rdat = word_t'(evect[`NCPU_AW-1:`NCPU_DW]);
         MSR_IMR:      msr_rdat = imr;
         MSR_IRR:      msr_rdat = irr;
         default:      msr_rdat = '0;
      endcase
   end

   // Entry logic must never save and restore at once
   a_take_onehot: assert property (@(posedge clk) disable iff (!arst_n)
      !(exc_take && eret_take));

endmodule

// ==== src/epu_top.sv ====
//****************************************
// EPU interrupt slice, top level
// Core drives MSR and retire ports
//****************************************

`timescale 1ns/1ps

`include "ncpu_config.svh"

module epu_top (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic [`NCPU_NUM_IRQ-1:0] irqs,
   input  ncpu_pkg::msr_addr_e      msr_addr,
   input  logic                     msr_we,
   input  ncpu_pkg::word_t          msr_wdat,
   input  logic                     retire_valid,
   input  ncpu_pkg::addr_t          retire_pc,
   input  logic                     eret,
   output ncpu_pkg::word_t          msr_rdat,
   output logic                     flush,
   output ncpu_pkg::addr_t          flush_pc
);
   import ncpu_pkg::*;

   // Controller to MSR file and back
   word_t imr;
   word_t irr;
   word_t imr_nxt;
   logic  imr_we;
   logic  psr_ire;
   logic  irq_async;

   // Entry logic to MSR file and back
   logic  exc_take;
   logic  eret_take;
   addr_t epc;
   addr_t evect;

   epu_irqc epu_irqc_i (
      .clk, .arst_n, .irqs, .psr_ire, .imr_we, .imr_nxt,
      .irq_async, .imr, .irr
   );

   epu_msr_file epu_msr_file_i (
      .clk, .arst_n, .msr_addr, .msr_we, .msr_wdat, .exc_take, .eret_take,
      .retire_pc, .imr, .irr, .msr_rdat, .imr_we, .imr_nxt, .psr_ire, .epc, .evect
   );

   epu_irq_entry epu_irq_entry_i (
      .clk, .arst_n, .retire_valid, .eret, .irq_async, .epc, .evect,
      .exc_take, .eret_take, .flush, .flush_pc
   );

endmodule

// ==== src/ncpu_config.svh ====
//****************************************
// Build-time sizes of the EPU interrupt slice
// Include wherever a width or reset value is needed
//****************************************

`ifndef NCPU_CONFIG_SVH
`define NCPU_CONFIG_SVH

// Data word width
`define NCPU_DW 32

// Program counter width, two data words
`define NCPU_AW 64

// External interrupt lines, no more than NCPU_DW
`define NCPU_NUM_IRQ 8

// Exception vector after reset
`define NCPU_EVECT_RST 64'h100

// MSR select width
`define NCPU_MSR_AW 3

`endif

// ==== src/ncpu_pkg.sv ====
//****************************************
// Shared types and MSR map of the EPU
//****************************************

`include "ncpu_config.svh"

package ncpu_pkg;

   // Data word and program counter
   typedef logic [`NCPU_DW-1:0] word_t;
   typedef logic [`NCPU_AW-1:0] addr_t;

   // MSR select, one 32-bit slot each
   typedef enum logic [`NCPU_MSR_AW-1:0] {
      MSR_PSR      = 0,
      MSR_EPSR     = 1,
      MSR_EPC_LO   = 2,
      MSR_EPC_HI   = 3,
      MSR_EVECT_LO = 4,
      MSR_EVECT_HI = 5,
      MSR_IMR      = 6,
      MSR_IRR      = 7
   } msr_addr_e;

   // Global interrupt enable in PSR
   localparam int PSR_IRE_BIT = 0;

endpackage
